// ==== list.f ====
+incdir+hdl
hdl/core_pkg.sv
hdl/core_s2_gen_imm.sv
hdl/core_s2_alu_ctrl.sv
hdl/core_s2_decode.sv
hdl/core_s2_stage.sv
sim/core_s2_checker.sv
sim/core_s2_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the decode stage testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module core_s2_tb -f list.f -o core_s2_sim \
    && ./obj_dir/core_s2_sim 2>&1 | tee sim.log

grep -q "SIMULATION PASSED" sim.log 2>/dev/null \
    && echo "Run passed" \
    || { echo "Run failed"; exit 1; }

// ==== sim/core_s2_tb.sv ====
// ####################
// Decode stage testbench
// Directed, ALU sweep, random and halt tests against a reference decode
// ####################

`timescale 1ns/1ps

module core_s2_tb;

    localparam int          RANDOM_COUNT   = 1500;
    // About twice the length of all tests together
    localparam int unsigned TIMEOUT_CYCLES = 4000;

    // One result in flight with the cycle its word was issued
    typedef struct packed {
        core_pkg::word_t       word;
        core_pkg::decode_out_t exp;
        logic [31:0]           tag;
    } pending_t;

    logic                  clk = 1'b0;
    logic                  rst = 1'b1;
    core_pkg::word_t       instruction = '0;
    logic                  instr_valid = 1'b0;
    core_pkg::decode_out_t dec;
    logic                  dec_valid;
    logic                  halted;

    pending_t    pending_q[$];
    int unsigned cycle = 0;
    int          errors = 0;
    int          compared = 0;

    // Every format with both immediate signs followed by illegal words
    core_pkg::word_t directed_words [22] = '{
        32'h002081b3, 32'h407302b3, 32'h0020a2af, 32'hffb10093, 32'h06452283,
        32'h000080e7, 32'h0ff0000f, 32'hfe512c23, 32'h00a12423, 32'hfe208ee3,
        32'h00209463, 32'h123450b7, 32'hfffff517, 32'hffdff0ef, 32'h008000ef,
        32'h3400d073, 32'h00000000, 32'hffffffff, 32'h00000011, 32'h0000001f,
        32'h00000057, 32'h0000007f
    };
    // Supported opcodes without CUSTOM_0 so random words never halt
    logic [4:0] legal_ops [12] = '{
        5'h00, 5'h03, 5'h04, 5'h05, 5'h08, 5'h0b, 5'h0c, 5'h0d, 5'h18, 5'h19, 5'h1b, 5'h1c
    };

    core_s2_stage core_s2_stage_i (
        .clk         (clk),
        .rst         (rst),
        .instruction (instruction),
        .instr_valid (instr_valid),
        .dec         (dec),
        .dec_valid   (dec_valid),
        .halted      (halted)
    );

    bind core_s2_stage core_s2_checker core_s2_checker_i (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .dec         (dec),
        .dec_valid   (dec_valid),
        .halted      (halted)
    );

    always #4 clk = ~clk;

    // Expected decode built straight from the RV32I field layout
    function automatic core_pkg::decode_out_t model_decode(input core_pkg::word_t w);
        core_pkg::decode_out_t r;
        logic [4:0]            op;
        logic [2:0]            f3;
        logic signed [31:0]    t;
        r  = '0;
        op = w[6:2];
        f3 = w[14:12];
        r.illegal_instr = !(op inside {5'h00, 5'h02, 5'h03, 5'h04, 5'h05, 5'h08, 5'h0b,
                                       5'h0c, 5'h0d, 5'h18, 5'h19, 5'h1b, 5'h1c}) ||
                          (w[1:0] != 2'b11) || (w == 32'h0) || (w == 32'hffff_ffff);
        r.halt_req = (op == 5'h02);
        r.rd       = w[11:7];
        r.rs1      = w[19:15];
        r.rs2      = w[24:20];
        r.uimm     = {27'd0, w[19:15]};
        // Immediate bits packed at the top and shifted down arithmetically
        case (op)
            5'h00, 5'h03, 5'h04, 5'h19: t = $signed({w[31:20], 20'd0}) >>> 20;
            5'h08: t = $signed({w[31:25], w[11:7], 20'd0}) >>> 20;
            5'h18: t = $signed({w[31], w[7], w[30:25], w[11:8], 1'b0, 19'd0}) >>> 19;
            5'h05, 5'h0d: t = {w[31:12], 12'd0};
            5'h1b: t = $signed({w[31], w[19:12], w[20], w[30:21], 1'b0, 11'd0}) >>> 11;
            default: t = '0;
        endcase
        r.immediate     = t;
        r.alu_operation = core_pkg::ALU_ADD;
        if (op == 5'h0c || op == 5'h04) begin
            case (f3)
                3'd0: if (op == 5'h0c && w[30]) r.alu_operation = core_pkg::ALU_SUB;
                3'd1: r.alu_operation = core_pkg::ALU_SLL;
                3'd2: r.alu_operation = core_pkg::ALU_SLT;
                3'd3: r.alu_operation = core_pkg::ALU_SLTU;
                3'd4: r.alu_operation = core_pkg::ALU_XOR;
                3'd5: r.alu_operation = w[30] ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
                3'd6: r.alu_operation = core_pkg::ALU_OR;
                default: r.alu_operation = core_pkg::ALU_AND;
            endcase
        end else if (op == 5'h0d) begin
            r.alu_operation = core_pkg::ALU_PASS_B;
        end else if (op == 5'h18) begin
            // BEQ/BNE subtract, signed and unsigned compares, reserved ones add
            if (f3 <= 3'd1) r.alu_operation = core_pkg::ALU_SUB;
            else if (f3 == 3'd4 || f3 == 3'd5) r.alu_operation = core_pkg::ALU_SLT;
            else if (f3 >= 3'd6) r.alu_operation = core_pkg::ALU_SLTU;
        end
        return r;
    endfunction

    task automatic report_error(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        errors++;
    endtask

    // One word per falling edge and queued only when a result must come back
    task automatic drive_word(input core_pkg::word_t w, input bit expect_result);
        pending_t p;
        @(negedge clk);
        instruction = w;
        instr_valid = 1'b1;
        if (expect_result) begin
            p.word = w;
            p.exp  = model_decode(w);
            p.tag  = cycle;
            pending_q.push_back(p);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            instr_valid = 1'b0;
        end
    endtask

    task automatic drain();
        idle_cycles(1);
        while (pending_q.size() != 0) @(negedge clk);
    endtask

    task automatic apply_reset();
        rst         = 1'b1;
        instr_valid = 1'b0;
        repeat (2) @(negedge clk);
        rst = 1'b0;
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin : monitor
        pending_t p;
        if (dec_valid) begin
            assert (pending_q.size() != 0) else report_error("dec_valid with nothing in flight");
            if (pending_q.size() != 0) begin
                p = pending_q.pop_front();
                compared++;
                assert (cycle - p.tag == 2)
                    else report_error($sformatf("word %h latency %0d", p.word, cycle - p.tag));
                assert (dec === p.exp)
                    else report_error($sformatf("word %h dec %h expected %h", p.word, dec, p.exp));
                // Halt rises with the result that requests it and not before
                assert (halted === p.exp.halt_req)
                    else report_error($sformatf("word %h halted %b", p.word, halted));
            end
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle == TIMEOUT_CYCLES) begin
            $display("Timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        int              i;
        int              idx;
        core_pkg::word_t w;
        void'($urandom(32'h61d2));
        apply_reset();
        foreach (directed_words[k]) drive_word(directed_words[k], 1'b1);
        // Bit 4 picks OP or OP_IMM, bit 3 is funct7 bit 5, low bits are funct3
        for (i = 0; i < 32; i++) begin
            w = {1'b0, i[3], 5'd0, 5'd7, 5'd6, i[2:0], 5'd5, (i[4] ? 7'h33 : 7'h13)};
            drive_word(w, 1'b1);
        end
        for (i = 0; i < 8; i++) begin
            drive_word({7'd0, 5'd2, 5'd1, i[2:0], 5'd0, 7'h63}, 1'b1);
        end
        drain();
        // Back-to-back random words with three quarters on a supported opcode
        for (i = 0; i < RANDOM_COUNT; i++) begin
            w = $urandom();
            if (($urandom() & 32'h3) != 0) begin
                idx     = $urandom_range(11, 0);
                w[6:0]  = {legal_ops[idx], 2'b11};
            end else if (w[6:2] == 5'h02) begin
                w[6:2] = 5'h03;
            end
            drive_word(w, 1'b1);
        end
        drain();
        // Halt word and a follower that the stage drops
        drive_word(32'h0000000b, 1'b1);
        drive_word(32'h002081b3, 1'b0);
        idle_cycles(1);
        while (!halted) @(negedge clk);
        for (i = 0; i < 4; i++) drive_word(32'h00100093 + i, 1'b0);
        idle_cycles(4);
        assert (pending_q.size() == 0) else report_error("halt result never arrived");
        assert (halted) else report_error("halted fell without reset");
        apply_reset();
        assert (!halted && !dec_valid && dec == '0) else report_error("reset left state set");
        drive_word(32'h00a12423, 1'b1);
        drive_word(32'hffdff0ef, 1'b1);
        drain();
        $display("Run complete, %0d results compared, %0d errors", compared, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule : core_s2_tb

// ==== sim/core_s2_checker.sv ====
// ####################
// Decode stage checker
// Strobe latency, reset and halt properties
// ####################

`timescale 1ns/1ps

module core_s2_checker (
    input logic                  clk,
    input logic                  rst,
    input logic                  instr_valid,
    input core_pkg::decode_out_t dec,
    input logic                  dec_valid,
    input logic                  halted
);

    // Accepted strobe comes out two cycles later
    // Unless a halt arrived in between and dropped it
    a_latency_fwd: assert property (@(posedge clk) disable iff (rst)
        ($past(instr_valid, 2) && !$past(halted, 2)) |-> (dec_valid || halted))
        else $error("dec_valid missing two cycles after instr_valid");

    // No result without a strobe two cycles earlier
    a_latency_back: assert property (@(posedge clk) disable iff (rst)
        dec_valid |-> $past(instr_valid, 2))
        else $error("dec_valid without a matching instr_valid");

    // Clean outputs right after a reset cycle
    a_reset: assert property (@(posedge clk)
        rst |=> (!dec_valid && !halted && dec == '0))
        else $error("outputs not cleared after rst");

    // Halt is sticky
    a_halt_sticky: assert property (@(posedge clk)
        (halted && !rst) |=> halted)
        else $error("halted dropped without rst");

    // Nothing leaves the stage once halted
    a_halt_quiet: assert property (@(posedge clk)
        (halted && !rst) |=> !dec_valid)
        else $error("dec_valid while halted");

endmodule : core_s2_checker

// ==== hdl/core_s2_stage.sv ====
// ####################
// Decode stage top
// Input register, decoder, result register, sticky halt
// ####################

`timescale 1ns/1ps

module core_s2_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  core_pkg::word_t       instruction,
    input  logic                  instr_valid,
    output core_pkg::decode_out_t dec,
    output logic                  dec_valid,
    output logic                  halted
);

    // Input side
    core_pkg::word_t       instr_q;
    logic                  instr_valid_q;
    logic                  accept;

    // Output side
    core_pkg::decode_out_t dec_d;
    logic                  issue;

    // Fetch strobes are ignored once halted
    assign accept = instr_valid & ~halted;

    // Word holds its value between strobes
    always_ff @(posedge clk) begin
        if (accept) begin
            instr_q <= instruction;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            instr_valid_q <= 1'b0;
        end else begin
            instr_valid_q <= accept;
        end
    end

    core_s2_decode core_s2_decode_i (
        .instruction (instr_q),
        .dec         (dec_d)
    );

    // A word still in the input register when halted rises is dropped here
    assign issue = instr_valid_q & ~halted;

    always_ff @(posedge clk) begin
        if (rst) begin
            dec       <= '0;
            dec_valid <= 1'b0;
            halted    <= 1'b0;
        end else begin
            dec_valid <= issue;
            // Result only updates on a real issue
            if (issue) begin
                dec <= dec_d;
            end
            // Sticky until reset
            // Rises with the same edge that registers the halt result
            if (issue && dec_d.halt_req) begin
                halted <= 1'b1;
            end
        end
    end

endmodule : core_s2_stage

// ==== hdl/core_s2_decode.sv ====
// ####################
// Instruction decoder
// Legality, format, halt flag, immediates and ALU op
// ####################

`timescale 1ns/1ps

`include "core_defs.svh"

module core_s2_decode (
    input  core_pkg::word_t       instruction,
    output core_pkg::decode_out_t dec
);

    core_pkg::opcode_e       opcode;
    logic                    unsupported_opcode;
    core_pkg::instr_format_e instr_format;
    core_pkg::word_t         immediate;
    core_pkg::word_t         uimm;
    core_pkg::aluop_e        alu_operation;

    // Major opcode from bits 6 to 2
    assign opcode = core_pkg::opcode_e'(instruction[`CORE_OPCODE_HI:`CORE_OPCODE_LO]);

    always_comb begin
        unique case (opcode)
            core_pkg::OPCODE_LOAD, core_pkg::OPCODE_CUSTOM_0, core_pkg::OPCODE_MISC_MEM,
            core_pkg::OPCODE_OP_IMM, core_pkg::OPCODE_AUIPC, core_pkg::OPCODE_STORE,
            core_pkg::OPCODE_AMO, core_pkg::OPCODE_OP, core_pkg::OPCODE_LUI,
            core_pkg::OPCODE_BRANCH, core_pkg::OPCODE_JALR, core_pkg::OPCODE_JAL,
            core_pkg::OPCODE_SYSTEM: begin
                unsupported_opcode = 1'b0;
            end
            default: begin
                unsupported_opcode = 1'b1;
            end
        endcase
    end

    // Format selection
    // SYSTEM and CUSTOM_0 fall into OTHER
    always_comb begin
        unique case (opcode)
            core_pkg::OPCODE_OP, core_pkg::OPCODE_AMO: begin
                instr_format = core_pkg::INSTR_FORMAT_R;
            end
            core_pkg::OPCODE_LOAD, core_pkg::OPCODE_MISC_MEM,
            core_pkg::OPCODE_OP_IMM, core_pkg::OPCODE_JALR: begin
                instr_format = core_pkg::INSTR_FORMAT_I;
            end
            core_pkg::OPCODE_STORE:  instr_format = core_pkg::INSTR_FORMAT_S;
            core_pkg::OPCODE_BRANCH: instr_format = core_pkg::INSTR_FORMAT_B;
            core_pkg::OPCODE_LUI, core_pkg::OPCODE_AUIPC: begin
                instr_format = core_pkg::INSTR_FORMAT_U;
            end
            core_pkg::OPCODE_JAL:    instr_format = core_pkg::INSTR_FORMAT_J;
            default:                 instr_format = core_pkg::INSTR_FORMAT_OTHER;
        endcase
    end

    core_s2_gen_imm core_s2_gen_imm_i (
        .instruction  (instruction),
        .instr_format (instr_format),
        .immediate    (immediate),
        .uimm         (uimm)
    );

    core_s2_alu_ctrl core_s2_alu_ctrl_i (
        .opcode        (opcode),
        .funct3        (instruction[`CORE_FUNCT3_HI:`CORE_FUNCT3_LO]),
        .funct7_b5     (instruction[`CORE_FUNCT7_B5]),
        .alu_operation (alu_operation)
    );

    // Pack the result
    // Compressed encodings and the all-zero/all-ones words are rejected
    always_comb begin
        dec.illegal_instr = unsupported_opcode || (instruction[1:0] != 2'b11) ||
                            (instruction == '0) || (instruction == '1);
        dec.halt_req      = (opcode == core_pkg::OPCODE_CUSTOM_0);
        dec.immediate     = immediate;
        dec.uimm          = uimm;
        dec.rd            = instruction[`CORE_RD_HI:`CORE_RD_LO];
        dec.rs1           = instruction[`CORE_RS1_HI:`CORE_RS1_LO];
        dec.rs2           = instruction[`CORE_RS2_HI:`CORE_RS2_LO];
        dec.alu_operation = alu_operation;
    end

endmodule : core_s2_decode

// ==== hdl/core_s2_alu_ctrl.sv ====
// ####################
// ALU control
// Maps opcode and funct fields to an ALU operation
// ####################

`timescale 1ns/1ps

module core_s2_alu_ctrl (
    input  core_pkg::opcode_e opcode,
    input  logic [2:0]        funct3,
    input  logic              funct7_b5,
    output core_pkg::aluop_e  alu_operation
);

    // Register-register and register-immediate arithmetic
    core_pkg::aluop_e arith_op;
    // Comparison used to resolve a branch
    core_pkg::aluop_e branch_op;

    always_comb begin
        unique case (funct3)
            3'b000: begin
                // SUB only exists for register-register
                if (opcode == core_pkg::OPCODE_OP && funct7_b5) begin
                    arith_op = core_pkg::ALU_SUB;
                end else begin
                    arith_op = core_pkg::ALU_ADD;
                end
            end
            3'b001: arith_op = core_pkg::ALU_SLL;
            3'b010: arith_op = core_pkg::ALU_SLT;
            3'b011: arith_op = core_pkg::ALU_SLTU;
            3'b100: arith_op = core_pkg::ALU_XOR;
            // funct7 bit 5 picks arithmetic shift for both OP and OP_IMM
            3'b101: arith_op = funct7_b5 ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
            3'b110: arith_op = core_pkg::ALU_OR;
            default: arith_op = core_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        unique case (funct3[2:1])
            // BEQ and BNE test the difference for zero
            2'b00: branch_op = core_pkg::ALU_SUB;
            2'b10: branch_op = core_pkg::ALU_SLT;
            2'b11: branch_op = core_pkg::ALU_SLTU;
            // Reserved branch encodings
            default: branch_op = core_pkg::ALU_ADD;
        endcase
    end

    always_comb begin
        unique case (opcode)
            core_pkg::OPCODE_OP,
            core_pkg::OPCODE_OP_IMM: alu_operation = arith_op;
            core_pkg::OPCODE_LUI:    alu_operation = core_pkg::ALU_PASS_B;
            core_pkg::OPCODE_BRANCH: alu_operation = branch_op;
            // Loads, stores, AUIPC, jumps and AMO all add
            // Address or link computation
            default:                 alu_operation = core_pkg::ALU_ADD;
        endcase
    end

endmodule : core_s2_alu_ctrl

// ==== hdl/core_s2_gen_imm.sv ====
// ####################
// Immediate generator
// Sign-extended immediate per format and CSR uimm
// ####################

`timescale 1ns/1ps

`include "core_defs.svh"

module core_s2_gen_imm (
    input  core_pkg::word_t         instruction,
    input  core_pkg::instr_format_e instr_format,
    output core_pkg::word_t         immediate,
    output core_pkg::word_t         uimm
);

    // Sign bit of every RV32 immediate
    logic sign;

    assign sign = instruction[`CORE_XLEN-1];

    always_comb begin
        unique case (instr_format)
            core_pkg::INSTR_FORMAT_I: begin
                // imm[11:0] sits in bits 31 to 20
                immediate = {{20{sign}}, instruction[31:20]};
            end
            core_pkg::INSTR_FORMAT_S: begin
                // Split around the rd slot
                immediate = {{20{sign}}, instruction[31:25],
                             instruction[`CORE_RD_HI:`CORE_RD_LO]};
            end
            core_pkg::INSTR_FORMAT_B: begin
                // Halfword offset with bit 0 implied zero
                immediate = {{19{sign}}, sign, instruction[7],
                             instruction[30:25], instruction[11:8], 1'b0};
            end
            core_pkg::INSTR_FORMAT_U: begin
                // Upper 20 bits over 12 cleared low bits
                immediate = {instruction[31:12], 12'd0};
            end
            core_pkg::INSTR_FORMAT_J: begin
                // JAL offset in scrambled bit order
                immediate = {{11{sign}}, sign, instruction[19:12],
                             instruction[20], instruction[30:21], 1'b0};
            end
            default: begin
                // R and OTHER carry no immediate
                immediate = '0;
            end
        endcase
    end

    // CSR immediate forms reuse the rs1 slot as a 5-bit unsigned value
    assign uimm = {{(`CORE_XLEN-`CORE_REG_IDX_W){1'b0}},
                   instruction[`CORE_RS1_HI:`CORE_RS1_LO]};

endmodule : core_s2_gen_imm

// ==== hdl/core_pkg.sv ====
// ####################
// Core package
// Shared types for the decode stage
// ####################

`include "core_defs.svh"

package core_pkg;

    // Plain vector types
    typedef logic [`CORE_XLEN-1:0]      word_t;
    typedef logic [`CORE_REG_IDX_W-1:0] reg_idx_t;

    // Major opcodes taken from instruction bits 6 to 2
    typedef enum logic [4:0] {
        OPCODE_LOAD     = 5'b00000,
        OPCODE_CUSTOM_0 = 5'b00010,
        OPCODE_MISC_MEM = 5'b00011,
        OPCODE_OP_IMM   = 5'b00100,
        OPCODE_AUIPC    = 5'b00101,
        OPCODE_STORE    = 5'b01000,
        OPCODE_AMO      = 5'b01011,
        OPCODE_OP       = 5'b01100,
        OPCODE_LUI      = 5'b01101,
        OPCODE_BRANCH   = 5'b11000,
        OPCODE_JALR     = 5'b11001,
        OPCODE_JAL      = 5'b11011,
        OPCODE_SYSTEM   = 5'b11100
    } opcode_e;

    // Instruction encoding formats
    typedef enum logic [2:0] {
        INSTR_FORMAT_R,
        INSTR_FORMAT_I,
        INSTR_FORMAT_S,
        INSTR_FORMAT_B,
        INSTR_FORMAT_U,
        INSTR_FORMAT_J,
        INSTR_FORMAT_OTHER
    } instr_format_e;

    // ALU operations
    // PASS_B forwards the second operand untouched (LUI)
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } aluop_e;

    // Decoded result handed to the next stage
    typedef struct packed {
        logic     illegal_instr;
        logic     halt_req;
        word_t    immediate;
        // CSR immediate as the zero-extended rs1 field
        word_t    uimm;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        aluop_e   alu_operation;
    } decode_out_t;

endpackage : core_pkg

// ==== hdl/core_defs.svh ====
// ####################
// Core definitions
// Fixed RV32I widths and instruction field positions
// ####################

`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Word and register index widths
`define CORE_XLEN       32
`define CORE_REG_IDX_W  5

// Major opcode lives in bits 6 to 2
// Bits 1 to 0 are always 11 for 32-bit encodings
`define CORE_OPCODE_LO  2
`define CORE_OPCODE_HI  6

// Register and function fields
`define CORE_RD_LO      7
`define CORE_RD_HI      11
`define CORE_FUNCT3_LO  12
`define CORE_FUNCT3_HI  14
`define CORE_RS1_LO     15
`define CORE_RS1_HI     19
`define CORE_RS2_LO     20
`define CORE_RS2_HI     24
`define CORE_FUNCT7_B5  30

`endif
